//--- src.f
hart_pkg.sv
core_status.sv
scramble_key_mgr.sv
rf_bank.sv
rf_pair.sv
hart_shell.sv
tb_hart_shell.sv

//--- tb_hart_shell.sv
/* Testbench for the hart shell: stimulus, reference model
   and concurrent checks on the register files, sleep, key and alerts */

`timescale 1ns/10ps
`default_nettype none

module tb_hart_shell;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               core_busy, debug_req, irq_pending, irq_nm;
  logic                               core_alert_minor, core_alert_major_internal;
  logic                               core_alert_major_bus;
  logic                               core_sleep, alert_minor, alert_major_internal;
  logic                               alert_major_bus;
  logic                               icache_inval, key_strobe, scramble_req, key_valid;
  logic [hart_pkg::ScrKeyW-1:0]       key_in, key_out;
  logic [hart_pkg::ScrNonceW-1:0]     nonce_in, nonce_out;
  logic [hart_pkg::RegAddrW-1:0]      raddr_a, raddr_b, waddr;
  hart_pkg::rf_sel_e                  sel_a, sel_b, wsel;
  logic                               we;
  logic [hart_pkg::XLEN-1:0]          wdata, rdata_a, rdata_b;

  // Reference model
  logic [hart_pkg::XLEN-1:0]          int_model [hart_pkg::NumRegs];
  logic [hart_pkg::XLEN-1:0]          fp_model [hart_pkg::NumRegs];
  logic [hart_pkg::XLEN-1:0]          exp_rdata_a, exp_rdata_b;
  logic                               busy_prev, exp_sleep;
  hart_pkg::key_state_e               exp_state;
  logic [hart_pkg::ScrKeyW-1:0]       exp_key;
  logic [hart_pkg::ScrNonceW-1:0]     exp_nonce;

  integer seed;
  int     rf_errors, sleep_errors, key_errors, alert_errors, timeout_errors;

  hart_shell hart_shell_inst (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .core_busy_i(core_busy), .debug_req_i(debug_req),
    .irq_pending_i(irq_pending), .irq_nm_i(irq_nm),
    .core_alert_minor_i(core_alert_minor),
    .core_alert_major_internal_i(core_alert_major_internal),
    .core_alert_major_bus_i(core_alert_major_bus),
    .core_sleep_o(core_sleep), .alert_minor_o(alert_minor),
    .alert_major_internal_o(alert_major_internal), .alert_major_bus_o(alert_major_bus),
    .icache_inval_i(icache_inval), .scramble_key_valid_i(key_strobe),
    .scramble_key_i(key_in), .scramble_nonce_i(nonce_in),
    .scramble_req_o(scramble_req), .key_valid_o(key_valid),
    .scramble_key_o(key_out), .scramble_nonce_o(nonce_out),
    .rf_raddr_a_i(raddr_a), .rf_raddr_b_i(raddr_b),
    .rf_sel_a_i(sel_a), .rf_sel_b_i(sel_b),
    .rf_waddr_i(waddr), .rf_wsel_i(wsel), .rf_we_i(we), .rf_wdata_i(wdata),
    .rf_rdata_a_o(rdata_a), .rf_rdata_b_o(rdata_b)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Model
  ////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < hart_pkg::NumRegs; i++) begin
        int_model[i] <= '0;
        fp_model[i]  <= '0;
      end
      busy_prev <= 1'b0;
      exp_state <= hart_pkg::KEY_READY;
      exp_key   <= hart_pkg::RstScrKey;
      exp_nonce <= hart_pkg::RstScrNonce;
    end else begin
      busy_prev <= core_busy;
      // x0 writes are dropped
      if (we && wsel == hart_pkg::RF_INT && waddr != '0) int_model[waddr] <= wdata;
      if (we && wsel == hart_pkg::RF_FP) fp_model[waddr] <= wdata;
      if (exp_state == hart_pkg::KEY_READY && icache_inval) begin
        exp_state <= hart_pkg::KEY_REQUEST;
      end else if (exp_state == hart_pkg::KEY_REQUEST && key_strobe) begin
        exp_state <= hart_pkg::KEY_READY;
      end
      if (key_strobe) begin
        exp_key   <= key_in;
        exp_nonce <= nonce_in;
      end
    end
  end

  assign exp_rdata_a = (sel_a == hart_pkg::RF_FP) ? fp_model[raddr_a] : int_model[raddr_a];
  assign exp_rdata_b = (sel_b == hart_pkg::RF_FP) ? fp_model[raddr_b] : int_model[raddr_b];
  assign exp_sleep   = !(busy_prev || debug_req || irq_pending || irq_nm);

  ////////////////////
  // Checks
  ////////////////////

  rd_a_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) rdata_a == exp_rdata_a)
    else begin
      rf_errors++;
      $display("[FAIL] %0t read port A got %h, expected %h", $time,
               $sampled(rdata_a), $sampled(exp_rdata_a));
    end

  rd_b_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) rdata_b == exp_rdata_b)
    else begin
      rf_errors++;
      $display("[FAIL] %0t read port B got %h, expected %h", $time,
               $sampled(rdata_b), $sampled(exp_rdata_b));
    end

  sleep_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) core_sleep == exp_sleep)
    else begin
      sleep_errors++;
      $display("[FAIL] %0t core_sleep_o is %b, expected %b", $time,
               $sampled(core_sleep), $sampled(exp_sleep));
    end

  state_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scramble_req == (exp_state == hart_pkg::KEY_REQUEST) &&
    key_valid == (exp_state == hart_pkg::KEY_READY))
    else begin
      key_errors++;
      $display("[FAIL] %0t req/valid are %b/%b in model state %s", $time,
               $sampled(scramble_req), $sampled(key_valid), exp_state.name());
    end

  key_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_out == exp_key && nonce_out == exp_nonce)
    else begin
      key_errors++;
      $display("[FAIL] %0t key/nonce %h/%h, expected %h/%h", $time,
               $sampled(key_out), $sampled(nonce_out), $sampled(exp_key), $sampled(exp_nonce));
    end

  alert_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_minor == core_alert_minor && alert_major_internal == core_alert_major_internal &&
    alert_major_bus == core_alert_major_bus)
    else begin
      alert_errors++;
      $display("[FAIL] %0t alert outputs do not follow the core alert inputs", $time);
    end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic hart_pkg::rf_sel_e pick_bank();
    return (($random(seed) & 1) != 0) ? hart_pkg::RF_FP : hart_pkg::RF_INT;
  endfunction

  // Wake sources sparse so that sleep shows up often enough
  task automatic step();
    core_busy                 = (($random(seed) & 3) == 0);
    debug_req                 = (($random(seed) & 7) == 0);
    irq_pending               = (($random(seed) & 7) == 0);
    irq_nm                    = (($random(seed) & 7) == 0);
    core_alert_minor          = (($random(seed) & 1) != 0);
    core_alert_major_internal = (($random(seed) & 1) != 0);
    core_alert_major_bus      = (($random(seed) & 1) != 0);
    @(negedge clk_i);
  endtask

  task automatic rf_write(input hart_pkg::rf_sel_e sel, input logic [4:0] addr,
                          input logic [31:0] data);
    we    = 1'b1;
    wsel  = sel;
    waddr = addr;
    wdata = data;
    step();
    we = 1'b0;
  endtask

  task automatic rf_read(input hart_pkg::rf_sel_e sa, input logic [4:0] aa,
                         input hart_pkg::rf_sel_e sb, input logic [4:0] ab);
    sel_a   = sa;
    raddr_a = aa;
    sel_b   = sb;
    raddr_b = ab;
    step();
  endtask

  task automatic random_traffic(input int cycles);
    repeat (cycles) begin
      we      = (($random(seed) & 1) != 0);
      wsel    = pick_bank();
      waddr   = $random(seed);
      wdata   = $random(seed);
      sel_a   = pick_bank();
      sel_b   = pick_bank();
      raddr_a = $random(seed);
      raddr_b = $random(seed);
      step();
    end
    we = 1'b0;
  endtask

  task automatic wait_key_state(input logic want_req);
    int cycles;
    cycles = 0;
    while ((scramble_req !== want_req || key_valid !== !want_req) && cycles < 20) begin
      step();
      cycles++;
    end
    if (scramble_req !== want_req || key_valid !== !want_req) begin
      timeout_errors++;
      $display("Timed out at %0t waiting for scramble_req_o to become %b", $time, want_req);
    end
  endtask

  task automatic key_strobe_random();
    key_strobe = 1'b1;
    key_in     = {$random(seed), $random(seed), $random(seed), $random(seed)};
    nonce_in   = {$random(seed), $random(seed)};
    step();
    key_strobe = 1'b0;
  endtask

  task automatic key_round();
    int idle;
    idle = 1 + ($random(seed) & 7);
    icache_inval = 1'b1;
    step();
    icache_inval = 1'b0;
    wait_key_state(1'b1);
    repeat (idle) step();
    key_strobe_random();
    wait_key_state(1'b0);
    step();
  endtask

  initial begin
    seed = 32'h245f;
    {rf_errors, sleep_errors, key_errors, alert_errors, timeout_errors} = '0;
    rst_ni = 1'b0;
    {core_busy, debug_req, irq_pending, irq_nm} = '0;
    {core_alert_minor, core_alert_major_internal, core_alert_major_bus} = '0;
    {icache_inval, key_strobe, we} = '0;
    key_in   = '0;
    nonce_in = '0;
    {raddr_a, raddr_b, waddr} = '0;
    sel_a = hart_pkg::RF_INT;
    sel_b = hart_pkg::RF_INT;
    wsel  = hart_pkg::RF_INT;
    wdata = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) step();

    // x0 hard zero, f0 stores, banks kept apart
    rf_write(hart_pkg::RF_INT, 5'd0, 32'hdead_beef);
    rf_write(hart_pkg::RF_FP, 5'd0, 32'h1234_5678);
    rf_read(hart_pkg::RF_INT, 5'd0, hart_pkg::RF_FP, 5'd0);
    rf_write(hart_pkg::RF_INT, 5'd7, 32'ha5a5_0f0f);
    rf_write(hart_pkg::RF_FP, 5'd7, 32'h5a5a_f0f0);
    rf_read(hart_pkg::RF_INT, 5'd7, hart_pkg::RF_FP, 5'd7);
    random_traffic(300);

    // Key loads in KEY_READY as well
    key_strobe_random();
    repeat (4) key_round();
    repeat (2) step();

    $display("Errors: rf=%0d sleep=%0d key=%0d alert=%0d timeout=%0d",
             rf_errors, sleep_errors, key_errors, alert_errors, timeout_errors);
    if (rf_errors + sleep_errors + key_errors + alert_errors + timeout_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hart_shell.sv
/* Top level of the hart shell: status and alerts,
   scramble key manager and the integer / FP register files */

`timescale 1ns/10ps
`default_nettype none

module hart_shell (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Status and alerts
  input  logic                             core_busy_i,
  input  logic                             debug_req_i,
  input  logic                             irq_pending_i,
  input  logic                             irq_nm_i,
  input  logic                             core_alert_minor_i,
  input  logic                             core_alert_major_internal_i,
  input  logic                             core_alert_major_bus_i,
  output logic                             core_sleep_o,
  output logic                             alert_minor_o,
  output logic                             alert_major_internal_o,
  output logic                             alert_major_bus_o,
  // Scramble key
  input  logic                             icache_inval_i,
  input  logic                             scramble_key_valid_i,
  input  logic [hart_pkg::ScrKeyW-1:0]     scramble_key_i,
  input  logic [hart_pkg::ScrNonceW-1:0]   scramble_nonce_i,
  output logic                             scramble_req_o,
  output logic                             key_valid_o,
  output logic [hart_pkg::ScrKeyW-1:0]     scramble_key_o,
  output logic [hart_pkg::ScrNonceW-1:0]   scramble_nonce_o,
  // Register file port
  input  logic [hart_pkg::RegAddrW-1:0]    rf_raddr_a_i,
  input  logic [hart_pkg::RegAddrW-1:0]    rf_raddr_b_i,
  input  hart_pkg::rf_sel_e                rf_sel_a_i,
  input  hart_pkg::rf_sel_e                rf_sel_b_i,
  input  logic [hart_pkg::RegAddrW-1:0]    rf_waddr_i,
  input  hart_pkg::rf_sel_e                rf_wsel_i,
  input  logic                             rf_we_i,
  input  logic [hart_pkg::XLEN-1:0]        rf_wdata_i,
  output logic [hart_pkg::XLEN-1:0]        rf_rdata_a_o,
  output logic [hart_pkg::XLEN-1:0]        rf_rdata_b_o
);

  core_status status_inst (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .core_busy_i                (core_busy_i),
    .debug_req_i                (debug_req_i),
    .irq_pending_i              (irq_pending_i),
    .irq_nm_i                   (irq_nm_i),
    .core_alert_minor_i         (core_alert_minor_i),
    .core_alert_major_internal_i(core_alert_major_internal_i),
    .core_alert_major_bus_i     (core_alert_major_bus_i),
    .core_sleep_o               (core_sleep_o),
    .alert_minor_o              (alert_minor_o),
    .alert_major_internal_o     (alert_major_internal_o),
    .alert_major_bus_o          (alert_major_bus_o)
  );

  scramble_key_mgr key_mgr_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (key_valid_o),
    .scramble_key_o      (scramble_key_o),
    .scramble_nonce_o    (scramble_nonce_o)
  );

  rf_pair rf_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rf_raddr_a_i(rf_raddr_a_i),
    .rf_raddr_b_i(rf_raddr_b_i),
    .rf_sel_a_i  (rf_sel_a_i),
    .rf_sel_b_i  (rf_sel_b_i),
    .rf_waddr_i  (rf_waddr_i),
    .rf_wsel_i   (rf_wsel_i),
    .rf_we_i     (rf_we_i),
    .rf_wdata_i  (rf_wdata_i),
    .rf_rdata_a_o(rf_rdata_a_o),
    .rf_rdata_b_o(rf_rdata_b_o)
  );

endmodule

`default_nettype wire

//--- rf_pair.sv
/* Integer and floating-point register banks sharing one
   write port and two read ports through select strobes */

`timescale 1ns/10ps
`default_nettype none

module rf_pair (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [hart_pkg::RegAddrW-1:0] rf_raddr_a_i,
  input  logic [hart_pkg::RegAddrW-1:0] rf_raddr_b_i,
  input  hart_pkg::rf_sel_e             rf_sel_a_i,
  input  hart_pkg::rf_sel_e             rf_sel_b_i,
  input  logic [hart_pkg::RegAddrW-1:0] rf_waddr_i,
  input  hart_pkg::rf_sel_e             rf_wsel_i,
  input  logic                          rf_we_i,
  input  logic [hart_pkg::XLEN-1:0]     rf_wdata_i,
  output logic [hart_pkg::XLEN-1:0]     rf_rdata_a_o,
  output logic [hart_pkg::XLEN-1:0]     rf_rdata_b_o
);

  logic                      int_we, fp_we;
  logic [hart_pkg::XLEN-1:0] int_rdata_a, int_rdata_b;
  logic [hart_pkg::XLEN-1:0] fp_rdata_a, fp_rdata_b;

  assign int_we = rf_we_i & (rf_wsel_i == hart_pkg::RF_INT);
  assign fp_we  = rf_we_i & (rf_wsel_i == hart_pkg::RF_FP);

  // x0 is hard zero in the integer bank only
  rf_bank #(.ZeroReg(1'b1)) int_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .we_i     (int_we),
    .wdata_i  (rf_wdata_i),
    .rdata_a_o(int_rdata_a),
    .rdata_b_o(int_rdata_b)
  );

  rf_bank #(.ZeroReg(1'b0)) fp_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .we_i     (fp_we),
    .wdata_i  (rf_wdata_i),
    .rdata_a_o(fp_rdata_a),
    .rdata_b_o(fp_rdata_b)
  );

  assign rf_rdata_a_o = (rf_sel_a_i == hart_pkg::RF_FP) ? fp_rdata_a : int_rdata_a;
  assign rf_rdata_b_o = (rf_sel_b_i == hart_pkg::RF_FP) ? fp_rdata_b : int_rdata_b;

  wsel_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_i |-> !$isunknown(rf_wsel_i));

endmodule

`default_nettype wire

//--- rf_bank.sv
/* Flip-flop register bank, one write port, two combinational
   read ports and an optional hard-zero entry 0 */

`timescale 1ns/10ps
`default_nettype none

module rf_bank #(
  parameter bit ZeroReg = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [hart_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [hart_pkg::RegAddrW-1:0] raddr_b_i,
  input  logic [hart_pkg::RegAddrW-1:0] waddr_i,
  input  logic                          we_i,
  input  logic [hart_pkg::XLEN-1:0]     wdata_i,
  output logic [hart_pkg::XLEN-1:0]     rdata_a_o,
  output logic [hart_pkg::XLEN-1:0]     rdata_b_o
);

  logic [hart_pkg::XLEN-1:0] regs [hart_pkg::NumRegs];

  for (genvar i = 0; i < hart_pkg::NumRegs; i++) begin : gen_regs
    if (ZeroReg && i == 0) begin : gen_zero
      // Hard zero, no storage
      assign regs[i] = '0;
    end else begin : gen_flop
      logic                      we;
      logic [hart_pkg::XLEN-1:0] q;

      assign we = we_i && (waddr_i == hart_pkg::RegAddrW'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          q <= '0;
        end else if (we) begin
          q <= wdata_i;
        end
      end

      assign regs[i] = q;
    end
  end

  // No write bypass, reads see the stored value only
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

//--- scramble_key_mgr.sv
/* Scramble key and nonce registers with the
   key request / key valid state machine */

`timescale 1ns/10ps
`default_nettype none

module scramble_key_mgr (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             icache_inval_i,
  input  logic                             scramble_key_valid_i,
  input  logic [hart_pkg::ScrKeyW-1:0]     scramble_key_i,
  input  logic [hart_pkg::ScrNonceW-1:0]   scramble_nonce_i,
  output logic                             scramble_req_o,
  output logic                             key_valid_o,
  output logic [hart_pkg::ScrKeyW-1:0]     scramble_key_o,
  output logic [hart_pkg::ScrNonceW-1:0]   scramble_nonce_o
);

  hart_pkg::key_state_e state_q, state_d;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hart_pkg::KEY_READY: begin
        if (icache_inval_i) begin
          state_d = hart_pkg::KEY_REQUEST;
        end
      end
      hart_pkg::KEY_REQUEST: begin
        // Request held open until the new key shows up
        if (scramble_key_valid_i) begin
          state_d = hart_pkg::KEY_READY;
        end
      end
      default: state_d = hart_pkg::KEY_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= hart_pkg::KEY_READY;
    end else begin
      state_q <= state_d;
    end
  end

  assign scramble_req_o = (state_q == hart_pkg::KEY_REQUEST);
  assign key_valid_o    = (state_q == hart_pkg::KEY_READY);

  ////////////////////
  // Key and nonce
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scramble_key_o   <= hart_pkg::RstScrKey;
      scramble_nonce_o <= hart_pkg::RstScrNonce;
    end else if (scramble_key_valid_i) begin
      scramble_key_o   <= scramble_key_i;
      scramble_nonce_o <= scramble_nonce_i;
    end
  end

  req_valid_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && key_valid_o));

  key_returns_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scramble_req_o && scramble_key_valid_i) |=> key_valid_o);

endmodule

`default_nettype wire

//--- core_status.sv
/* Busy register, sleep indicator and alert merging */

`timescale 1ns/10ps
`default_nettype none

module core_status (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic core_alert_minor_i,
  input  logic core_alert_major_internal_i,
  input  logic core_alert_major_bus_i,
  output logic core_sleep_o,
  output logic alert_minor_o,
  output logic alert_major_internal_o,
  output logic alert_major_bus_o
);

  logic core_busy_q;
  logic wake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake sources act at once, busy one cycle late
  assign wake         = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~wake;

  assign alert_minor_o          = core_alert_minor_i;
  assign alert_major_internal_o = core_alert_major_internal_i;
  assign alert_major_bus_o      = core_alert_major_bus_i;

  nmi_wakes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_nm_i |-> !core_sleep_o);

endmodule

`default_nettype wire

//--- hart_pkg.sv
/* Shared widths, scramble reset constants and enums
   for the hart shell, its status logic and register files */

`default_nettype none

package hart_pkg;

  // Register file geometry
  localparam int unsigned XLEN     = 32;
  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = 5;

  // Scramble key and nonce
  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  localparam logic [ScrKeyW-1:0]   RstScrKey   = 128'h0a3c_5f92_e417_b86d_2c90_71fe_d453_8b16;
  localparam logic [ScrNonceW-1:0] RstScrNonce = 64'h9e61_47b2_3dc8_05af;

  // Interrupts
  localparam int unsigned NumFastIrq = 15;

  // Key manager states
  typedef enum logic {
    KEY_READY   = 1'b0,
    KEY_REQUEST = 1'b1
  } key_state_e;

  // Bank addressed by a register file port
  typedef enum logic {
    RF_INT = 1'b0,
    RF_FP  = 1'b1
  } rf_sel_e;

endpackage

`default_nettype wire
